// ==== flist.f ====
mips_pkg.sv
funct_gen.sv
operand_gen.sv
branch_unit.sv
mem_ctrl.sv
exc_detect.sv
id_ex_reg.sv
id_stage.sv
tb_clk_gen.sv
tb_id_stage.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --top-module tb_id_stage -f flist.f
	./obj_dir/Vtb_id_stage | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;

    // ctl is {load_related_1, load_related_2, delayslot_flag_in}
    // cflags is {read_en_1, read_en_2, stall, branch, next delay slot}
    // rflags is {delay slot, mem read, mem write, sign ext, write enable}
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] addr;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [2:0]  ctl;
        logic [4:0]  cflags;
        logic [4:0]  raddr1;
        logic [4:0]  raddr2;
        logic [31:0] br_addr;
        logic [4:0]  rflags;
        logic [5:0]  funct;
        logic [4:0]  shamt;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [3:0]  sel;
        logic [31:0] wdata;
        logic [4:0]  waddr;
        logic [7:0]  exc;
    } row_t;

    localparam int NUM_ROWS = 24;

    localparam row_t ROWS [NUM_ROWS] = '{
        // addi, ori, lui, addu, sll
        '{32'h2023fff0, 32'h400000, 32'h5, 32'h7, 3'b000, 5'b10000, 5'd1, 5'd0,
          32'h0, 5'b00001, 6'h20, 5'h1f, 32'h5, 32'hfffffff0, 4'h0, 32'h0, 5'd3, 8'h04},
        '{32'h34448001, 32'h400004, 32'hf0, 32'h7, 3'b000, 5'b10000, 5'd2, 5'd0,
          32'h0, 5'b00001, 6'h25, 5'h00, 32'hf0, 32'h8001, 4'h0, 32'h0, 5'd4, 8'h00},
        '{32'h3c051234, 32'h400008, 32'hdeadbeef, 32'h7, 3'b000, 5'b00000, 5'd0, 5'd0,
          32'h0, 5'b00001, 6'h25, 5'h08, 32'h0, 32'h12340000, 4'h0, 32'h0, 5'd5, 8'h00},
        '{32'h00223021, 32'h40000c, 32'h10, 32'h20, 3'b000, 5'b11000, 5'd1, 5'd2,
          32'h0, 5'b00001, 6'h21, 5'h00, 32'h10, 32'h20, 4'h0, 32'h0, 5'd6, 8'h00},
        '{32'h00023900, 32'h400010, 32'h0, 32'hf, 3'b000, 5'b11000, 5'd0, 5'd2,
          32'h0, 5'b00001, 6'h00, 5'h04, 32'h0, 32'hf, 4'h0, 32'h0, 5'd7, 8'h00},
        // lb, lhu, lw, sb, sw
        '{32'h8128fffc, 32'h400014, 32'h10000010, 32'h55, 3'b000, 5'b10000, 5'd9, 5'd0,
          32'h0, 5'b01011, 6'h21, 5'h1f, 32'h10000010, 32'hfffffffc, 4'h1, 32'h0, 5'd8, 8'h00},
        '{32'h952a0006, 32'h400018, 32'h10000010, 32'h55, 3'b000, 5'b10000, 5'd9, 5'd0,
          32'h0, 5'b01001, 6'h21, 5'h00, 32'h10000010, 32'h6, 4'h3, 32'h0, 5'd10, 8'h00},
        '{32'h8c0b0100, 32'h40001c, 32'h0, 32'h55, 3'b000, 5'b10000, 5'd0, 5'd0,
          32'h0, 5'b01011, 6'h21, 5'h04, 32'h0, 32'h100, 4'hf, 32'h0, 5'd11, 8'h00},
        '{32'ha1ac0003, 32'h400020, 32'h20000000, 32'hab, 3'b000, 5'b11000, 5'd13, 5'd12,
          32'h0, 5'b00100, 6'h21, 5'h00, 32'h20000000, 32'h3, 4'h1, 32'hab, 5'd0, 8'h00},
        '{32'hadaefff8, 32'h400024, 32'h20000000, 32'hf00d, 3'b000, 5'b11000, 5'd13, 5'd14,
          32'h0, 5'b00100, 6'h21, 5'h1f, 32'h20000000, 32'hfffffff8, 4'hf, 32'hf00d, 5'd0, 8'h00},
        // load hazards, bubble expected in the register
        '{32'h00223021, 32'h400028, 32'h10, 32'h20, 3'b100, 5'b11100, 5'd1, 5'd2,
          32'h0, 5'b00000, 6'h00, 5'h00, 32'h0, 32'h0, 4'h0, 32'h0, 5'd0, 8'h00},
        '{32'hadaefff8, 32'h40002c, 32'h20000000, 32'hf00d, 3'b011, 5'b11100, 5'd13, 5'd14,
          32'h0, 5'b00000, 6'h00, 5'h00, 32'h0, 32'h0, 4'h0, 32'h0, 5'd0, 8'h00},
        // beq taken, beq not taken, bgtz negative, bltzal, j, jr
        '{32'h10220004, 32'h400100, 32'h33, 32'h33, 3'b000, 5'b11011, 5'd1, 5'd2,
          32'h400114, 5'b00000, 6'h00, 5'h00, 32'h33, 32'h0, 4'h0, 32'h0, 5'd0, 8'h00},
        '{32'h1022fffe, 32'h400104, 32'h33, 32'h34, 3'b000, 5'b11001, 5'd1, 5'd2,
          32'h0, 5'b00000, 6'h00, 5'h1f, 32'h33, 32'h0, 4'h0, 32'h0, 5'd0, 8'h00},
        '{32'h1ca00008, 32'h400108, 32'h80000000, 32'h7, 3'b001, 5'b11001, 5'd5, 5'd0,
          32'h0, 5'b10000, 6'h00, 5'h00, 32'h80000000, 32'h0, 4'h0, 32'h0, 5'd0, 8'h00},
        '{32'h04d0fffe, 32'h400100, 32'hfffffff0, 32'h7, 3'b000, 5'b10011, 5'd6, 5'd0,
          32'h4000fc, 5'b00001, 6'h21, 5'h1f, 32'h400108, 32'h0, 4'h0, 32'h0, 5'd31, 8'h00},
        '{32'h08123456, 32'h10400100, 32'h77, 32'h88, 3'b000, 5'b00011, 5'd0, 5'd0,
          32'h1048d158, 5'b00000, 6'h00, 5'h11, 32'h0, 32'h0, 4'h0, 32'h0, 5'd0, 8'h00},
        '{32'h03e00008, 32'h400200, 32'h400500, 32'h0, 3'b000, 5'b11011, 5'd31, 5'd0,
          32'h400500, 5'b00001, 6'h08, 5'h00, 32'h400500, 32'h0, 4'h0, 32'h0, 5'd0, 8'h00},
        // undefined opcode, cp0, unknown funct, add, syscall, break
        '{32'hfc000000, 32'h400300, 32'h1, 32'h2, 3'b000, 5'b00000, 5'd0, 5'd0,
          32'h0, 5'b00000, 6'h00, 5'h00, 32'h0, 32'h0, 4'h0, 32'h0, 5'd0, 8'h02},
        '{32'h40026000, 32'h400304, 32'h1, 32'h2, 3'b000, 5'b00000, 5'd0, 5'd0,
          32'h0, 5'b00000, 6'h00, 5'h00, 32'h0, 32'h0, 4'h0, 32'h0, 5'd0, 8'h02},
        '{32'h0022183f, 32'h400308, 32'h11, 32'h22, 3'b000, 5'b11000, 5'd1, 5'd2,
          32'h0, 5'b00001, 6'h3f, 5'h00, 32'h11, 32'h22, 4'h0, 32'h0, 5'd3, 8'h02},
        '{32'h00221820, 32'h40030c, 32'h7fffffff, 32'h1, 3'b000, 5'b11000, 5'd1, 5'd2,
          32'h0, 5'b00001, 6'h20, 5'h00, 32'h7fffffff, 32'h1, 4'h0, 32'h0, 5'd3, 8'h04},
        '{32'h0000000c, 32'h400310, 32'h0, 32'h0, 3'b000, 5'b11000, 5'd0, 5'd0,
          32'h0, 5'b00001, 6'h0c, 5'h00, 32'h0, 32'h0, 4'h0, 32'h0, 5'd0, 8'h20},
        '{32'h0000000d, 32'h400314, 32'h0, 32'h0, 3'b000, 5'b11000, 5'd0, 5'd0,
          32'h0, 5'b00001, 6'h0d, 5'h00, 32'h0, 32'h0, 4'h0, 32'h0, 5'd0, 8'h10}
    };

    logic        clk, rst;
    logic [31:0] addr, inst, reg_data_1, reg_data_2;
    logic        load_related_1, load_related_2, delayslot_flag_in;
    logic        reg_read_en_1, reg_read_en_2, stall_request, branch_flag;
    logic        next_delayslot_flag_out, delayslot_flag_out, write_reg_en;
    logic        mem_read_flag, mem_write_flag, mem_sign_ext_flag;
    logic [4:0]  reg_addr_1, reg_addr_2, shamt, write_reg_addr;
    logic [31:0] branch_addr, operand_1, operand_2, mem_write_data, current_pc_addr;
    logic [5:0]  funct;
    logic [3:0]  mem_sel;
    logic [7:0]  exception_type;

    tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    id_stage dut_i (.*);

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic drive_row(input row_t r);
        inst <= r.inst;
        addr <= r.addr;
        reg_data_1 <= r.rd1;
        reg_data_2 <= r.rd2;
        {load_related_1, load_related_2, delayslot_flag_in} <= r.ctl;
    endtask

    // same-cycle outputs
    task automatic check_comb(input row_t r);
        check("reg_read_en_1", 32'(r.cflags[4]), 32'(reg_read_en_1));
        check("reg_read_en_2", 32'(r.cflags[3]), 32'(reg_read_en_2));
        check("stall_request", 32'(r.cflags[2]), 32'(stall_request));
        check("branch_flag", 32'(r.cflags[1]), 32'(branch_flag));
        check("next_delayslot_flag_out", 32'(r.cflags[0]), 32'(next_delayslot_flag_out));
        check("reg_addr_1", 32'(r.raddr1), 32'(reg_addr_1));
        check("reg_addr_2", 32'(r.raddr2), 32'(reg_addr_2));
        check("branch_addr", r.br_addr, branch_addr);
    endtask

    // outputs one edge later, a stalled row leaves a bubble
    task automatic check_regs(input row_t r);
        check("delayslot_flag_out", 32'(r.rflags[4]), 32'(delayslot_flag_out));
        check("mem_read_flag", 32'(r.rflags[3]), 32'(mem_read_flag));
        check("mem_write_flag", 32'(r.rflags[2]), 32'(mem_write_flag));
        check("mem_sign_ext_flag", 32'(r.rflags[1]), 32'(mem_sign_ext_flag));
        check("write_reg_en", 32'(r.rflags[0]), 32'(write_reg_en));
        check("funct", 32'(r.funct), 32'(funct));
        check("shamt", 32'(r.shamt), 32'(shamt));
        check("operand_1", r.op1, operand_1);
        check("operand_2", r.op2, operand_2);
        check("mem_sel", 32'(r.sel), 32'(mem_sel));
        check("mem_write_data", r.wdata, mem_write_data);
        check("write_reg_addr", 32'(r.waddr), 32'(write_reg_addr));
        check("exception_type", 32'(r.exc), 32'(exception_type));
        check("current_pc_addr", r.cflags[2] ? 32'h0 : r.addr, current_pc_addr);
    endtask

    initial begin
        repeat (NUM_ROWS * 4 + 20) @(posedge clk);
        $display("timeout, the watchdog expired before the last row was checked");
        $display("TEST FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        inst = '0;
        addr = '0;
        reg_data_1 = '0;
        reg_data_2 = '0;
        load_related_1 = 1'b0;
        load_related_2 = 1'b0;
        delayslot_flag_in = 1'b0;
        // bltzal with a hazard, every output would be active without reset
        @(posedge clk);
        inst <= 32'h04d0fffe;
        addr <= 32'h400100;
        reg_data_1 <= 32'hfffffff0;
        reg_data_2 <= 32'h7;
        load_related_1 <= 1'b1;
        delayslot_flag_in <= 1'b1;
        @(negedge clk);
        while (!rst) begin
            check_comb('0);
            check_regs('0);
            @(negedge clk);
        end
        check_regs('0);
        for (int i = 0; i <= NUM_ROWS; i++) begin
            @(posedge clk);
            if (i < NUM_ROWS) begin
                drive_row(ROWS[i]);
            end
            @(negedge clk);
            if (i < NUM_ROWS) begin
                check_comb(ROWS[i]);
            end
            if (i == 0) begin
                check_regs('0);
            end
            else begin
                check_regs(ROWS[i - 1]);
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held low for eight rising edges
    initial begin
        rst = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// ==== id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::word_t     addr,
    input  mips_pkg::inst_t     inst,
    input  logic                load_related_1,
    input  logic                load_related_2,
    input  logic                delayslot_flag_in,
    input  mips_pkg::word_t     reg_data_1,
    input  mips_pkg::word_t     reg_data_2,
    output logic                reg_read_en_1,
    output logic                reg_read_en_2,
    output mips_pkg::reg_addr_t reg_addr_1,
    output mips_pkg::reg_addr_t reg_addr_2,
    output logic                stall_request,
    output logic                branch_flag,
    output mips_pkg::word_t     branch_addr,
    output logic                next_delayslot_flag_out,
    output logic                delayslot_flag_out,
    output mips_pkg::funct_t    funct,
    output mips_pkg::shamt_t    shamt,
    output mips_pkg::word_t     operand_1,
    output mips_pkg::word_t     operand_2,
    output logic                mem_read_flag,
    output logic                mem_write_flag,
    output logic                mem_sign_ext_flag,
    output mips_pkg::mem_sel_t  mem_sel,
    output mips_pkg::word_t     mem_write_data,
    output logic                write_reg_en,
    output mips_pkg::reg_addr_t write_reg_addr,
    output mips_pkg::exc_t      exception_type,
    output mips_pkg::word_t     current_pc_addr
);

    // decoded values ahead of the stage register
    mips_pkg::funct_t    funct_d;
    mips_pkg::shamt_t    shamt_d;
    mips_pkg::word_t     operand_1_d;
    mips_pkg::word_t     operand_2_d;
    logic                mem_read_flag_d;
    logic                mem_write_flag_d;
    logic                mem_sign_ext_flag_d;
    mips_pkg::mem_sel_t  mem_sel_d;
    mips_pkg::word_t     mem_write_data_d;
    logic                write_reg_en_d;
    mips_pkg::reg_addr_t write_reg_addr_d;
    mips_pkg::exc_t      exception_type_d;

    assign shamt_d = inst[10:6];

    funct_gen funct_gen_i (.*, .funct(funct_d));

    operand_gen operand_gen_i (
        .*,
        .operand_1(operand_1_d),
        .operand_2(operand_2_d),
        .write_reg_en(write_reg_en_d),
        .write_reg_addr(write_reg_addr_d)
    );

    branch_unit branch_unit_i (.*);

    mem_ctrl mem_ctrl_i (
        .*,
        .mem_read_flag(mem_read_flag_d),
        .mem_write_flag(mem_write_flag_d),
        .mem_sign_ext_flag(mem_sign_ext_flag_d),
        .mem_sel(mem_sel_d),
        .mem_write_data(mem_write_data_d)
    );

    exc_detect exc_detect_i (.*, .exception_type(exception_type_d));

    id_ex_reg id_ex_reg_i (.*, .addr_d(addr));

endmodule

// ==== id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_related_1,
    input  logic                load_related_2,
    input  logic                delayslot_flag_in,
    input  mips_pkg::funct_t    funct_d,
    input  mips_pkg::shamt_t    shamt_d,
    input  mips_pkg::word_t     operand_1_d,
    input  mips_pkg::word_t     operand_2_d,
    input  logic                mem_read_flag_d,
    input  logic                mem_write_flag_d,
    input  logic                mem_sign_ext_flag_d,
    input  mips_pkg::mem_sel_t  mem_sel_d,
    input  mips_pkg::word_t     mem_write_data_d,
    input  logic                write_reg_en_d,
    input  mips_pkg::reg_addr_t write_reg_addr_d,
    input  mips_pkg::exc_t      exception_type_d,
    input  mips_pkg::word_t     addr_d,
    output logic                stall_request,
    output logic                delayslot_flag_out,
    output mips_pkg::funct_t    funct,
    output mips_pkg::shamt_t    shamt,
    output mips_pkg::word_t     operand_1,
    output mips_pkg::word_t     operand_2,
    output logic                mem_read_flag,
    output logic                mem_write_flag,
    output logic                mem_sign_ext_flag,
    output mips_pkg::mem_sel_t  mem_sel,
    output mips_pkg::word_t     mem_write_data,
    output logic                write_reg_en,
    output mips_pkg::reg_addr_t write_reg_addr,
    output mips_pkg::exc_t      exception_type,
    output mips_pkg::word_t     current_pc_addr
);

    // a source still waiting on a load result
    assign stall_request = rst && (load_related_1 || load_related_2);

    always_ff @(posedge clk) begin
        if (!rst || stall_request) begin
            // bubble, a nop with no side effects
            {delayslot_flag_out, funct, shamt, operand_1, operand_2,
             mem_read_flag, mem_write_flag, mem_sign_ext_flag, mem_sel,
             mem_write_data, write_reg_en, write_reg_addr,
             exception_type, current_pc_addr} <= '0;
        end
        else begin
            delayslot_flag_out <= delayslot_flag_in;
            funct <= funct_d;
            shamt <= shamt_d;
            operand_1 <= operand_1_d;
            operand_2 <= operand_2_d;
            mem_read_flag <= mem_read_flag_d;
            mem_write_flag <= mem_write_flag_d;
            mem_sign_ext_flag <= mem_sign_ext_flag_d;
            mem_sel <= mem_sel_d;
            mem_write_data <= mem_write_data_d;
            write_reg_en <= write_reg_en_d;
            write_reg_addr <= write_reg_addr_d;
            exception_type <= exception_type_d;
            current_pc_addr <= addr_d;
        end
    end

endmodule

// ==== exc_detect.sv ====
`timescale 1ns/1ps

module exc_detect (
    input  mips_pkg::inst_t inst,
    output mips_pkg::exc_t  exception_type
);

    mips_pkg::opcode_t   op;
    mips_pkg::reg_addr_t rt;
    mips_pkg::funct_t    fn;

    assign op = inst[31:26];
    assign rt = inst[20:16];
    assign fn = inst[5:0];

    always_comb begin
        // fetch, trap, address and eret causes are raised in other stages
        exception_type = '0;
        case (op)
            mips_pkg::OP_SPECIAL: begin
                case (fn)
                    mips_pkg::FUNCT_SLL, mips_pkg::FUNCT_SRL, mips_pkg::FUNCT_SRA,
                    mips_pkg::FUNCT_SLLV, mips_pkg::FUNCT_SRLV, mips_pkg::FUNCT_SRAV,
                    mips_pkg::FUNCT_JR, mips_pkg::FUNCT_JALR, mips_pkg::FUNCT_MOVZ,
                    mips_pkg::FUNCT_MOVN, mips_pkg::FUNCT_MFHI, mips_pkg::FUNCT_MTHI,
                    mips_pkg::FUNCT_MFLO, mips_pkg::FUNCT_MTLO, mips_pkg::FUNCT_MULT,
                    mips_pkg::FUNCT_MULTU, mips_pkg::FUNCT_DIV, mips_pkg::FUNCT_DIVU,
                    mips_pkg::FUNCT_ADDU, mips_pkg::FUNCT_SUBU, mips_pkg::FUNCT_AND,
                    mips_pkg::FUNCT_OR, mips_pkg::FUNCT_XOR, mips_pkg::FUNCT_NOR,
                    mips_pkg::FUNCT_SLT, mips_pkg::FUNCT_SLTU: ;
                    mips_pkg::FUNCT_ADD, mips_pkg::FUNCT_SUB: begin
                        exception_type[mips_pkg::EXC_OV] = 1'b1;
                    end
                    mips_pkg::FUNCT_SYSCALL: exception_type[mips_pkg::EXC_SYS] = 1'b1;
                    mips_pkg::FUNCT_BREAK: exception_type[mips_pkg::EXC_BP] = 1'b1;
                    default: exception_type[mips_pkg::EXC_RI] = 1'b1;
                endcase
            end
            mips_pkg::OP_REGIMM: begin
                if (!(rt inside {mips_pkg::REGIMM_BLTZ, mips_pkg::REGIMM_BGEZ,
                                 mips_pkg::REGIMM_BLTZAL, mips_pkg::REGIMM_BGEZAL})) begin
                    exception_type[mips_pkg::EXC_RI] = 1'b1;
                end
            end
            mips_pkg::OP_ADDI: exception_type[mips_pkg::EXC_OV] = 1'b1;
            mips_pkg::OP_J, mips_pkg::OP_JAL, mips_pkg::OP_BEQ, mips_pkg::OP_BNE,
            mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
            mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI,
            mips_pkg::OP_LUI, mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
            mips_pkg::OP_LBU, mips_pkg::OP_LHU, mips_pkg::OP_SB, mips_pkg::OP_SH,
            mips_pkg::OP_SW: ;
            // cp0 and special2 land here too
            default: exception_type[mips_pkg::EXC_RI] = 1'b1;
        endcase
    end

endmodule

// ==== mem_ctrl.sv ====
`timescale 1ns/1ps

module mem_ctrl (
    input  mips_pkg::inst_t    inst,
    input  mips_pkg::word_t    reg_data_2,
    output logic               mem_read_flag,
    output logic               mem_write_flag,
    output logic               mem_sign_ext_flag,
    output mips_pkg::mem_sel_t mem_sel,
    output mips_pkg::word_t    mem_write_data
);

    mips_pkg::opcode_t op;

    assign op = inst[31:26];

    assign mem_read_flag = op inside {mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
                                      mips_pkg::OP_LBU, mips_pkg::OP_LHU};
    assign mem_write_flag = op inside {mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW};
    assign mem_sign_ext_flag = op inside {mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW};
    assign mem_write_data = mem_write_flag ? reg_data_2 : '0;

    // byte lanes from access width
    always_comb begin
        case (op)
            mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_SB: mem_sel = 4'b0001;
            mips_pkg::OP_LH, mips_pkg::OP_LHU, mips_pkg::OP_SH: mem_sel = 4'b0011;
            mips_pkg::OP_LW, mips_pkg::OP_SW: mem_sel = 4'b1111;
            default: mem_sel = 4'b0000;
        endcase
    end

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  logic            rst,
    input  mips_pkg::inst_t inst,
    input  mips_pkg::word_t addr,
    input  mips_pkg::word_t reg_data_1,
    input  mips_pkg::word_t reg_data_2,
    output logic            branch_flag,
    output mips_pkg::word_t branch_addr,
    output logic            next_delayslot_flag_out
);

    mips_pkg::opcode_t   op;
    mips_pkg::reg_addr_t rt;
    mips_pkg::funct_t    fn;
    mips_pkg::half_t     offset;
    mips_pkg::word_t     pc_plus_4;
    mips_pkg::word_t     target;
    logic                is_branch;
    logic                taken;

    assign op = inst[31:26];
    assign rt = inst[20:16];
    assign fn = inst[5:0];
    assign offset = inst[15:0];
    assign pc_plus_4 = addr + 32'd4;

    always_comb begin
        is_branch = 1'b1;
        taken = 1'b0;
        target = pc_plus_4 + {{14{offset[15]}}, offset, 2'b00};
        case (op)
            mips_pkg::OP_J, mips_pkg::OP_JAL: begin
                taken = 1'b1;
                // stays inside the current 256 MB region
                target = {pc_plus_4[31:28], inst[25:0], 2'b00};
            end
            mips_pkg::OP_SPECIAL: begin
                is_branch = fn == mips_pkg::FUNCT_JR || fn == mips_pkg::FUNCT_JALR;
                taken = is_branch;
                target = reg_data_1;
            end
            mips_pkg::OP_BEQ:  taken = reg_data_1 == reg_data_2;
            mips_pkg::OP_BNE:  taken = reg_data_1 != reg_data_2;
            mips_pkg::OP_BLEZ: taken = reg_data_1[31] || reg_data_1 == '0;
            mips_pkg::OP_BGTZ: taken = !reg_data_1[31] && reg_data_1 != '0;
            mips_pkg::OP_REGIMM: begin
                case (rt)
                    mips_pkg::REGIMM_BLTZ, mips_pkg::REGIMM_BLTZAL: taken = reg_data_1[31];
                    mips_pkg::REGIMM_BGEZ, mips_pkg::REGIMM_BGEZAL: taken = !reg_data_1[31];
                    default: is_branch = 1'b0;
                endcase
            end
            default: is_branch = 1'b0;
        endcase
    end

    assign branch_flag = rst && taken;
    assign branch_addr = branch_flag ? target : '0;
    // a branch owns its delay slot even when not taken
    assign next_delayslot_flag_out = rst && is_branch;

endmodule

// ==== operand_gen.sv ====
`timescale 1ns/1ps

module operand_gen (
    input  logic                rst,
    input  mips_pkg::inst_t     inst,
    input  mips_pkg::word_t     addr,
    input  mips_pkg::word_t     reg_data_1,
    input  mips_pkg::word_t     reg_data_2,
    output logic                reg_read_en_1,
    output logic                reg_read_en_2,
    output mips_pkg::reg_addr_t reg_addr_1,
    output mips_pkg::reg_addr_t reg_addr_2,
    output mips_pkg::word_t     operand_1,
    output mips_pkg::word_t     operand_2,
    output logic                write_reg_en,
    output mips_pkg::reg_addr_t write_reg_addr
);

    mips_pkg::opcode_t   op;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::half_t     imm;
    mips_pkg::word_t     imm_sext;
    mips_pkg::word_t     link_addr;
    logic                regimm_ok;
    logic                is_link;

    assign op = inst[31:26];
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign imm = inst[15:0];
    assign imm_sext = {{16{imm[15]}}, imm};
    // return address skips the delay slot
    assign link_addr = addr + 32'd8;

    assign regimm_ok = op == mips_pkg::OP_REGIMM
        && rt inside {mips_pkg::REGIMM_BLTZ, mips_pkg::REGIMM_BGEZ,
                      mips_pkg::REGIMM_BLTZAL, mips_pkg::REGIMM_BGEZAL};
    assign is_link = op == mips_pkg::OP_JAL
        || (op == mips_pkg::OP_SPECIAL && inst[5:0] == mips_pkg::FUNCT_JALR)
        || (regimm_ok && rt[4]);

    assign reg_read_en_2 = rst && op inside {mips_pkg::OP_SPECIAL, mips_pkg::OP_BEQ,
        mips_pkg::OP_BNE, mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ,
        mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW};
    assign reg_read_en_1 = rst && (reg_read_en_2 || regimm_ok
        || op inside {mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
                      mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
                      mips_pkg::OP_XORI, mips_pkg::OP_LB, mips_pkg::OP_LH,
                      mips_pkg::OP_LW, mips_pkg::OP_LBU, mips_pkg::OP_LHU});
    assign reg_addr_1 = reg_read_en_1 ? rs : '0;
    assign reg_addr_2 = reg_read_en_2 ? rt : '0;

    always_comb begin
        operand_1 = reg_read_en_1 ? reg_data_1 : '0;
        operand_2 = '0;
        write_reg_en = 1'b0;
        write_reg_addr = '0;
        case (op)
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
                operand_2 = {16'b0, imm};
                write_reg_en = 1'b1;
                write_reg_addr = rt;
            end
            mips_pkg::OP_LUI: begin
                operand_2 = {imm, 16'b0};
                write_reg_en = 1'b1;
                write_reg_addr = rt;
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
            mips_pkg::OP_SLTIU, mips_pkg::OP_LB, mips_pkg::OP_LH,
            mips_pkg::OP_LW, mips_pkg::OP_LBU, mips_pkg::OP_LHU: begin
                operand_2 = imm_sext;
                write_reg_en = 1'b1;
                write_reg_addr = rt;
            end
            mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: operand_2 = imm_sext;
            mips_pkg::OP_SPECIAL: begin
                operand_2 = reg_data_2;
                write_reg_en = 1'b1;
                write_reg_addr = inst[15:11];
            end
            default: ;
        endcase
        if (is_link) begin
            operand_1 = link_addr;
            operand_2 = '0;
            // jalr keeps its rd
            if (op != mips_pkg::OP_SPECIAL) begin
                write_reg_en = 1'b1;
                write_reg_addr = mips_pkg::LINK_REG;
            end
        end
        if (!rst) begin
            operand_1 = '0;
            operand_2 = '0;
            write_reg_en = 1'b0;
            write_reg_addr = '0;
        end
    end

endmodule

// ==== funct_gen.sv ====
`timescale 1ns/1ps

module funct_gen (
    input  mips_pkg::inst_t  inst,
    output mips_pkg::funct_t funct
);

    mips_pkg::opcode_t   op;
    mips_pkg::reg_addr_t rt;

    assign op = inst[31:26];
    assign rt = inst[20:16];

    always_comb begin
        case (op)
            mips_pkg::OP_SPECIAL: funct = inst[5:0];
            mips_pkg::OP_ADDI:    funct = mips_pkg::FUNCT_ADD;
            mips_pkg::OP_ADDIU:   funct = mips_pkg::FUNCT_ADDU;
            mips_pkg::OP_SLTI:    funct = mips_pkg::FUNCT_SLT;
            mips_pkg::OP_SLTIU:   funct = mips_pkg::FUNCT_SLTU;
            mips_pkg::OP_ANDI:    funct = mips_pkg::FUNCT_AND;
            mips_pkg::OP_XORI:    funct = mips_pkg::FUNCT_XOR;
            // lui ors the shifted immediate into a zero operand 1
            mips_pkg::OP_ORI, mips_pkg::OP_LUI: funct = mips_pkg::FUNCT_OR;
            // address arithmetic and link address pass through addu
            mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
            mips_pkg::OP_LBU, mips_pkg::OP_LHU, mips_pkg::OP_SB,
            mips_pkg::OP_SH, mips_pkg::OP_SW, mips_pkg::OP_JAL: begin
                funct = mips_pkg::FUNCT_ADDU;
            end
            mips_pkg::OP_REGIMM: begin
                if (rt == mips_pkg::REGIMM_BLTZAL || rt == mips_pkg::REGIMM_BGEZAL) begin
                    funct = mips_pkg::FUNCT_ADDU;
                end
                else begin
                    funct = '0;
                end
            end
            default: funct = '0;
        endcase
    end

endmodule

// ==== mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] half_t;
    typedef logic [3:0]  mem_sel_t;
    typedef logic [7:0]  exc_t;

    // major opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SH      = 6'b101001;
    localparam opcode_t OP_SW      = 6'b101011;

    // r-type funct field, also the alu function code
    localparam funct_t FUNCT_SLL     = 6'h00;
    localparam funct_t FUNCT_SRL     = 6'h02;
    localparam funct_t FUNCT_SRA     = 6'h03;
    localparam funct_t FUNCT_SLLV    = 6'h04;
    localparam funct_t FUNCT_SRLV    = 6'h06;
    localparam funct_t FUNCT_SRAV    = 6'h07;
    localparam funct_t FUNCT_JR      = 6'h08;
    localparam funct_t FUNCT_JALR    = 6'h09;
    localparam funct_t FUNCT_MOVZ    = 6'h0a;
    localparam funct_t FUNCT_MOVN    = 6'h0b;
    localparam funct_t FUNCT_SYSCALL = 6'h0c;
    localparam funct_t FUNCT_BREAK   = 6'h0d;
    localparam funct_t FUNCT_MFHI    = 6'h10;
    localparam funct_t FUNCT_MTHI    = 6'h11;
    localparam funct_t FUNCT_MFLO    = 6'h12;
    localparam funct_t FUNCT_MTLO    = 6'h13;
    localparam funct_t FUNCT_MULT    = 6'h18;
    localparam funct_t FUNCT_MULTU   = 6'h19;
    localparam funct_t FUNCT_DIV     = 6'h1a;
    localparam funct_t FUNCT_DIVU    = 6'h1b;
    localparam funct_t FUNCT_ADD     = 6'h20;
    localparam funct_t FUNCT_ADDU    = 6'h21;
    localparam funct_t FUNCT_SUB     = 6'h22;
    localparam funct_t FUNCT_SUBU    = 6'h23;
    localparam funct_t FUNCT_AND     = 6'h24;
    localparam funct_t FUNCT_OR      = 6'h25;
    localparam funct_t FUNCT_XOR     = 6'h26;
    localparam funct_t FUNCT_NOR     = 6'h27;
    localparam funct_t FUNCT_SLT     = 6'h2a;
    localparam funct_t FUNCT_SLTU    = 6'h2b;

    // regimm codes live in the rt field
    localparam reg_addr_t REGIMM_BLTZ   = 5'b00000;
    localparam reg_addr_t REGIMM_BGEZ   = 5'b00001;
    localparam reg_addr_t REGIMM_BLTZAL = 5'b10000;
    localparam reg_addr_t REGIMM_BGEZAL = 5'b10001;

    // bit positions in exc_t
    localparam int EXC_IF   = 0;
    localparam int EXC_RI   = 1;
    localparam int EXC_OV   = 2;
    localparam int EXC_TP   = 3;
    localparam int EXC_BP   = 4;
    localparam int EXC_SYS  = 5;
    localparam int EXC_ADE  = 6;
    localparam int EXC_ERET = 7;

    localparam reg_addr_t LINK_REG = 5'd31;

endpackage
